// File: game_defs.svh
`ifndef GAME_DEFS_SVH
`define GAME_DEFS_SVH

// board geometry
`define BOARD_WIDTH       10
`define COORD_W           4

// field widths
`define PLAYER_W          3
`define PIECE_W           2
`define TROOP_W           9
`define ROUND_W           13

// crown placement and starting troops
`define RED_CROWN_H       2
`define RED_CROWN_V       3
`define BLUE_CROWN_H      8
`define BLUE_CROWN_V      7
`define RED_CROWN_TROOP   87
`define BLUE_CROWN_TROOP  89

// layout and move rules
`define MOUNTAIN_SUM      9     // h + v on the anti-diagonal
`define MIN_MOVE_TROOP    2     // one troop always stays behind

// cell readout bus
`define WB_ADR_W          8
`define WB_DAT_W          16

`endif

// File: game_pkg.sv
`include "game_defs.svh"

package game_pkg;

    typedef logic [`COORD_W-1:0] coord_t;
    typedef logic [`TROOP_W-1:0] troop_t;
    typedef logic [`ROUND_W-1:0] round_t;      // first round is 1

    typedef enum logic [`PLAYER_W-1:0] {NPC, RED, BLUE} player_e;

    typedef enum logic [`PIECE_W-1:0] {TERRITORY, MOUNTAIN, CROWN, CITY} piece_e;

    // upper bit set means a move mode
    typedef enum logic [1:0] {
        CHOOSE     = 2'b00,
        MOVE_TOTAL = 2'b10,
        MOVE_HALF  = 2'b11
    } cursor_mode_e;

    // W A S D SPACE Z
    typedef enum logic [2:0] {
        UP     = 3'd0,
        LEFT   = 3'd1,
        DOWN   = 3'd2,
        RIGHT  = 3'd3,
        SELECT = 3'd4,
        TOGGLE = 3'd5
    } key_op_e;

    typedef struct packed {
        coord_t h;     // upper nibble on the bus
        coord_t v;
    } pos_t;

    typedef struct packed {
        player_e owner;
        piece_e  piece;
        troop_t  troop;
    } cell_t;

    typedef struct packed {
        pos_t         cursor;
        cursor_mode_e mode;
        player_e      player;
        round_t       round;
        logic         busy;
    } game_status_t;

    typedef enum logic [2:0] {IDLE, EXEC, WR_TARGET, WR_SOURCE, TURN} fsm_state_e;

endpackage

// File: key_intake.sv
module key_intake (
    input  logic              clk_100M,
    input  logic              reset,
    input  logic              keyboard_ready,
    input  logic [2:0]        keyboard_data,
    output logic              keyboard_read_fin,
    output logic              op_valid,
    output game_pkg::key_op_e op,
    input  logic              op_take
);

    logic sample;
    logic code_ok;

    // a full buffer holds the decoder off by withholding read_fin
    assign sample  = keyboard_ready && !op_valid && !keyboard_read_fin;
    assign code_ok = (keyboard_data <= 3'(game_pkg::TOGGLE));   // 6 and 7 are dropped

    always_ff @(posedge clk_100M) begin
        if (reset) begin
            keyboard_read_fin <= 1'b0;
            op_valid          <= 1'b0;
        end else begin
            keyboard_read_fin <= sample;    // single cycle pulse
            if (sample && code_ok) begin
                op_valid <= 1'b1;
            end else if (op_take) begin
                op_valid <= 1'b0;
            end
        end
    end

    // op keeps its value after the take, fsm still reads it in EXEC
    always_ff @(posedge clk_100M) begin
        if (sample && code_ok) begin
            op <= game_pkg::key_op_e'(keyboard_data);
        end
    end

endmodule

// File: cursor_unit.sv
`include "game_defs.svh"

module cursor_unit (
    input  logic                clk_100M,
    input  logic                reset,
    input  game_pkg::key_op_e   op,
    input  logic                cursor_step,
    input  logic                cursor_jump,
    input  game_pkg::player_e   jump_player,
    output game_pkg::pos_t      cursor,
    output game_pkg::pos_t      target,
    output logic                target_ok
);

    localparam game_pkg::coord_t ONE  = game_pkg::coord_t'(1);
    localparam game_pkg::coord_t LAST = game_pkg::coord_t'(`BOARD_WIDTH - 1);

    game_pkg::pos_t crown_pos;

    // neighbour cell, stays on the cursor when the step would leave the board
    always_comb begin
        target    = cursor;
        target_ok = 1'b0;
        case (op)
            game_pkg::UP: begin
                target_ok = (cursor.v != '0);
                if (target_ok) target.v = cursor.v - ONE;
            end
            game_pkg::LEFT: begin
                target_ok = (cursor.h != '0);
                if (target_ok) target.h = cursor.h - ONE;
            end
            game_pkg::DOWN: begin
                target_ok = (cursor.v < LAST);
                if (target_ok) target.v = cursor.v + ONE;
            end
            game_pkg::RIGHT: begin
                target_ok = (cursor.h < LAST);
                if (target_ok) target.h = cursor.h + ONE;
            end
            default: ;  // SELECT and TOGGLE have no neighbour
        endcase
    end

    always_comb begin
        if (jump_player == game_pkg::BLUE) begin
            crown_pos = '{h: game_pkg::coord_t'(`BLUE_CROWN_H), v: game_pkg::coord_t'(`BLUE_CROWN_V)};
        end else begin
            crown_pos = '{h: game_pkg::coord_t'(`RED_CROWN_H), v: game_pkg::coord_t'(`RED_CROWN_V)};
        end
    end

    always_ff @(posedge clk_100M) begin
        if (reset) begin
            cursor <= '0;
        end else if (cursor_jump) begin
            cursor <= crown_pos;
        end else if (cursor_step) begin
            cursor <= target;
        end
    end

endmodule

// File: round_counter.sv
module round_counter (
    input  logic                clk_100M,
    input  logic                reset,
    input  logic                turn_end,
    output game_pkg::player_e   player,
    output game_pkg::round_t    round
);

    logic back_to_red;

    // a full round closes once BLUE has moved
    assign back_to_red = turn_end && (player == game_pkg::BLUE);

    always_ff @(posedge clk_100M) begin
        if (reset) begin
            player <= game_pkg::RED;
        end else if (turn_end) begin
            player <= (player == game_pkg::BLUE) ? game_pkg::RED : game_pkg::BLUE;
        end
    end

    always_ff @(posedge clk_100M) begin
        if (reset) begin
            round <= game_pkg::round_t'(1);
        end else if (back_to_red) begin
            round <= round + game_pkg::round_t'(1);
        end
    end

endmodule

// File: board_store.sv
`include "game_defs.svh"

module board_store (
    input  logic                    clk_100M,
    input  logic                    reset,
    input  game_pkg::pos_t          cursor,
    input  game_pkg::pos_t          target,
    output game_pkg::cell_t         cursor_cell,
    output game_pkg::cell_t         target_cell,
    input  logic                    wr_en,
    input  game_pkg::pos_t          wr_pos,
    input  game_pkg::cell_t         wr_cell,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic [`WB_ADR_W-1:0]    wb_adr,
    output logic [`WB_DAT_W-1:0]    wb_dat_o,
    output logic                    wb_ack
);

    localparam int PAD_W = `WB_DAT_W - $bits(game_pkg::cell_t);

    game_pkg::cell_t cells [`BOARD_WIDTH][`BOARD_WIDTH];   // indexed [h][v]
    game_pkg::pos_t  wb_pos;
    game_pkg::cell_t wb_cell;
    logic            wb_start;

    function automatic logic on_board(game_pkg::pos_t p);
        return (p.h < `BOARD_WIDTH) && (p.v < `BOARD_WIDTH);
    endfunction

    // starting board: mountains on the anti-diagonal, cities on the diagonal
    function automatic game_pkg::cell_t layout_cell(int h, int v);
        game_pkg::cell_t c;
        c = '{owner: game_pkg::NPC, piece: game_pkg::TERRITORY, troop: '0};
        if (h + v == `MOUNTAIN_SUM) c.piece = game_pkg::MOUNTAIN;
        if (h == v) c.piece = game_pkg::CITY;
        if (h == `RED_CROWN_H && v == `RED_CROWN_V) begin
            c = '{owner: game_pkg::RED, piece: game_pkg::CROWN,
                  troop: game_pkg::troop_t'(`RED_CROWN_TROOP)};
        end
        if (h == `BLUE_CROWN_H && v == `BLUE_CROWN_V) begin
            c = '{owner: game_pkg::BLUE, piece: game_pkg::CROWN,
                  troop: game_pkg::troop_t'(`BLUE_CROWN_TROOP)};
        end
        return c;
    endfunction

    always_ff @(posedge clk_100M) begin
        if (reset) begin
            for (int h = 0; h < `BOARD_WIDTH; h++) begin
                for (int v = 0; v < `BOARD_WIDTH; v++) begin
                    cells[h][v] <= layout_cell(h, v);
                end
            end
        end else if (wr_en) begin
            cells[wr_pos.h][wr_pos.v] <= wr_cell;
        end
    end

    // game side reads, no clock
    always_comb begin
        cursor_cell = on_board(cursor) ? cells[cursor.h][cursor.v] : '0;
        target_cell = on_board(target) ? cells[target.h][target.v] : '0;
    end

    // readout port, one ack per strobe
    assign wb_pos   = wb_adr;
    assign wb_start = wb_cyc && wb_stb && !wb_ack;

    always_comb begin
        wb_cell = on_board(wb_pos) ? cells[wb_pos.h][wb_pos.v] : '0;   // holes read as 0
    end

    always_ff @(posedge clk_100M) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_start;
        end
    end

    always_ff @(posedge clk_100M) begin
        if (wb_start) begin
            wb_dat_o <= {{PAD_W{1'b0}}, wb_cell};
        end
    end

endmodule

// File: game_fsm.sv
`include "game_defs.svh"

module game_fsm (
    input  logic                    clk_100M,
    input  logic                    reset,
    input  logic                    op_valid,
    input  game_pkg::key_op_e       op,
    output logic                    op_take,
    input  logic                    target_ok,
    output logic                    cursor_step,
    output logic                    cursor_jump,
    input  game_pkg::cell_t         cursor_cell,
    input  game_pkg::cell_t         target_cell,
    output logic                    wr_en,
    output game_pkg::pos_t          wr_pos,
    output game_pkg::cell_t         wr_cell,
    input  game_pkg::pos_t          cursor,
    input  game_pkg::pos_t          target,
    input  game_pkg::player_e       player,
    output logic                    turn_end,
    output game_pkg::cursor_mode_e  mode,
    output logic                    busy
);

    game_pkg::fsm_state_e   state;
    game_pkg::fsm_state_e   state_nxt;
    game_pkg::cursor_mode_e mode_nxt;
    game_pkg::pos_t         tgt_pos_q;
    game_pkg::cell_t        tgt_new_q;
    game_pkg::cell_t        src_new_q;
    game_pkg::troop_t       src_troop;
    game_pkg::troop_t       half_troop;
    logic                   is_dir;
    logic                   in_move;
    logic                   can_select;
    logic                   can_capture;

    assign src_troop  = cursor_cell.troop;
    assign half_troop = src_troop >> 1;
    assign is_dir     = (op == game_pkg::UP) || (op == game_pkg::LEFT) ||
                        (op == game_pkg::DOWN) || (op == game_pkg::RIGHT);
    assign in_move    = (mode != game_pkg::CHOOSE);
    assign can_select = (cursor_cell.owner == player) &&
                        (src_troop >= game_pkg::troop_t'(`MIN_MOVE_TROOP));
    // only neutral open ground or neutral cities can be taken
    assign can_capture = is_dir && target_ok && (target_cell.owner == game_pkg::NPC) &&
                         ((target_cell.piece == game_pkg::TERRITORY) ||
                          (target_cell.piece == game_pkg::CITY));
    assign busy = (state != game_pkg::IDLE);

    always_comb begin
        state_nxt   = state;
        mode_nxt    = mode;
        op_take     = 1'b0;
        cursor_step = 1'b0;
        cursor_jump = 1'b0;
        turn_end    = 1'b0;
        wr_en       = 1'b0;
        wr_pos      = tgt_pos_q;
        wr_cell     = tgt_new_q;
        case (state)
            game_pkg::IDLE: begin
                if (op_valid) begin
                    op_take   = 1'b1;
                    state_nxt = game_pkg::EXEC;
                end
            end
            game_pkg::EXEC: begin
                state_nxt = game_pkg::IDLE;
                if (!in_move) begin
                    if (is_dir) begin
                        cursor_step = target_ok;    // clamp at the edges
                    end else if (op == game_pkg::SELECT && can_select) begin
                        mode_nxt = game_pkg::MOVE_TOTAL;
                    end
                end else begin
                    case (op)
                        game_pkg::TOGGLE: begin
                            mode_nxt = (mode == game_pkg::MOVE_TOTAL) ? game_pkg::MOVE_HALF
                                                                      : game_pkg::MOVE_TOTAL;
                        end
                        game_pkg::SELECT: mode_nxt = game_pkg::CHOOSE;
                        default: begin
                            if (can_capture) state_nxt = game_pkg::WR_TARGET;
                        end
                    endcase
                end
            end
            game_pkg::WR_TARGET: begin
                wr_en     = 1'b1;
                state_nxt = game_pkg::WR_SOURCE;
            end
            game_pkg::WR_SOURCE: begin
                wr_en     = 1'b1;
                wr_pos    = cursor;         // source is still under the cursor
                wr_cell   = src_new_q;
                turn_end  = 1'b1;           // player flips here so TURN sees the next one
                state_nxt = game_pkg::TURN;
            end
            game_pkg::TURN: begin
                cursor_jump = 1'b1;
                mode_nxt    = game_pkg::CHOOSE;
                state_nxt   = game_pkg::IDLE;
            end
            default: state_nxt = game_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk_100M) begin
        if (reset) begin
            state <= game_pkg::IDLE;
            mode  <= game_pkg::CHOOSE;
        end else begin
            state <= state_nxt;
            mode  <= mode_nxt;
        end
    end

    // capture results, held for the two write cycles
    always_ff @(posedge clk_100M) begin
        if (state == game_pkg::EXEC) begin
            tgt_pos_q       <= target;
            tgt_new_q.owner <= player;
            tgt_new_q.piece <= target_cell.piece;
            src_new_q.owner <= cursor_cell.owner;
            src_new_q.piece <= cursor_cell.piece;
            if (mode == game_pkg::MOVE_TOTAL) begin
                tgt_new_q.troop <= src_troop - game_pkg::troop_t'(1);
                src_new_q.troop <= game_pkg::troop_t'(1);
            end else begin
                tgt_new_q.troop <= half_troop;
                src_new_q.troop <= src_troop - half_troop;   // odd counts keep the extra one
            end
        end
    end

endmodule

// File: game_player.sv
`include "game_defs.svh"

module game_player (
    input  logic                    clk_100M,
    input  logic                    reset,
    input  logic                    keyboard_ready,
    input  logic [2:0]              keyboard_data,
    output logic                    keyboard_read_fin,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic [`WB_ADR_W-1:0]    wb_adr,
    output logic [`WB_DAT_W-1:0]    wb_dat_o,
    output logic                    wb_ack,
    output game_pkg::game_status_t  status
);

    logic                   op_valid;
    game_pkg::key_op_e      op;
    logic                   op_take;
    logic                   cursor_step;
    logic                   cursor_jump;
    game_pkg::pos_t         cursor;
    game_pkg::pos_t         target;
    logic                   target_ok;
    game_pkg::cell_t        cursor_cell;
    game_pkg::cell_t        target_cell;
    logic                   wr_en;
    game_pkg::pos_t         wr_pos;
    game_pkg::cell_t        wr_cell;
    logic                   turn_end;
    game_pkg::player_e      player;
    game_pkg::round_t       round;
    game_pkg::cursor_mode_e mode;
    logic                   fsm_busy;

    key_intake u_key_intake (
        .clk_100M, .reset, .keyboard_ready, .keyboard_data, .keyboard_read_fin,
        .op_valid, .op, .op_take
    );

    // jump comes a cycle after turn_end, so player already names the next one
    cursor_unit u_cursor_unit (
        .clk_100M, .reset, .op, .cursor_step, .cursor_jump,
        .jump_player(player), .cursor, .target, .target_ok
    );

    round_counter u_round_counter (
        .clk_100M, .reset, .turn_end, .player, .round
    );

    board_store u_board_store (
        .clk_100M, .reset, .cursor, .target, .cursor_cell, .target_cell,
        .wr_en, .wr_pos, .wr_cell, .wb_cyc, .wb_stb, .wb_adr, .wb_dat_o, .wb_ack
    );

    game_fsm u_game_fsm (
        .clk_100M, .reset, .op_valid, .op, .op_take, .target_ok, .cursor_step,
        .cursor_jump, .cursor_cell, .target_cell, .wr_en, .wr_pos, .wr_cell,
        .cursor, .target, .player, .turn_end, .mode, .busy(fsm_busy)
    );

    // busy also covers an op waiting in the buffer
    assign status = '{cursor: cursor, mode: mode, player: player, round: round,
                      busy: op_valid | fsm_busy};

endmodule

// File: game_player_chk.sv
`include "game_defs.svh"

module game_player_chk (
    input  logic                   clk_100M,
    input  logic                   reset,
    input  logic                   keyboard_read_fin,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_ack,
    input  game_pkg::game_status_t status
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;

    // acknowledge is a single cycle pulse
    a_read_fin_pulse: assert property (@(posedge clk_100M) disable iff (reset)
        keyboard_read_fin |=> !keyboard_read_fin)
        else begin
            fail_count++;
            $error("keyboard_read_fin stayed high for two cycles");
        end

    a_ack_after_strobe: assert property (@(posedge clk_100M) disable iff (reset)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else begin
            fail_count++;
            $error("wb_ack rose without a preceding cyc and stb");
        end

    a_cursor_on_board: assert property (@(posedge clk_100M) disable iff (reset)
        (status.cursor.h < `BOARD_WIDTH) && (status.cursor.v < `BOARD_WIDTH))
        else begin
            fail_count++;
            $error("cursor left the board");
        end

    a_idle_after_reset: assert property (@(posedge clk_100M)
        reset |=> !status.busy)
        else begin
            fail_count++;
            $error("busy high right after reset");
        end

endmodule

bind game_player game_player_chk u_game_player_chk (
    .clk_100M, .reset, .keyboard_read_fin, .wb_cyc, .wb_stb, .wb_ack, .status
);

// File: tb_game_player.sv
`include "game_defs.svh"

module tb_game_player;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_OPS      = 400;
    localparam int KEY_TIMEOUT  = 40;
    localparam int BUSY_TIMEOUT = 40;
    localparam int WB_TIMEOUT   = 20;
    localparam int W            = `BOARD_WIDTH;

    logic                   clk_100M;
    logic                   reset;
    logic                   keyboard_ready;
    logic [2:0]             keyboard_data;
    logic                   keyboard_read_fin;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic [`WB_ADR_W-1:0]   wb_adr;
    logic [`WB_DAT_W-1:0]   wb_dat_o;
    logic                   wb_ack;
    game_pkg::game_status_t status;

    // reference model of the game
    game_pkg::cell_t        board [W][W];    // [h][v]
    game_pkg::pos_t         m_cursor;
    game_pkg::cursor_mode_e m_mode;
    game_pkg::player_e      m_player;
    game_pkg::round_t       m_round;
    int                     err_value;
    int                     err_proto;

    // walk to the RED crown, try the mode keys, capture, then one BLUE half capture
    logic [2:0] opening [$] = '{3, 3, 2, 2, 2, 7, 5, 4, 5, 5, 4, 4, 0, 6, 4, 5, 3, 4};

    game_player u_game_player (
        .clk_100M, .reset, .keyboard_ready, .keyboard_data, .keyboard_read_fin,
        .wb_cyc, .wb_stb, .wb_adr, .wb_dat_o, .wb_ack, .status
    );

    always #5 clk_100M = ~clk_100M;

    task automatic end_run();
        int asrt;
        asrt = u_game_player.u_game_player_chk.fail_count;
        $display("errors: %0d value, %0d protocol, %0d assertion", err_value, err_proto, asrt);
        if (err_value + err_proto + asrt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    task automatic report_timeout(string what);
        err_proto++;
        $display("timed out waiting for %s", what);
    endtask

    task automatic check_status(string name, game_pkg::game_status_t exp,
                                game_pkg::game_status_t act);
        if (act !== exp) begin
            err_value++;
            $display("ERR %s: expected status %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_cell(string name, game_pkg::cell_t exp, game_pkg::cell_t act);
        if (act !== exp) begin
            err_value++;
            $display("ERR %s: expected cell %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_pos(string name, game_pkg::pos_t exp, game_pkg::pos_t act);
        if (act !== exp) begin
            err_value++;
            $display("ERR %s: expected pos %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_round(string name, game_pkg::round_t exp, game_pkg::round_t act);
        if (act !== exp) begin
            err_value++;
            $display("ERR %s: expected round %0d, actual %0d", name, exp, act);
        end
    endtask

    function automatic game_pkg::cell_t layout_cell(int h, int v);
        game_pkg::cell_t c;
        c.owner = game_pkg::NPC;
        c.troop = '0;
        if (h == `RED_CROWN_H && v == `RED_CROWN_V) begin
            c.owner = game_pkg::RED;
            c.piece = game_pkg::CROWN;
            c.troop = game_pkg::troop_t'(`RED_CROWN_TROOP);
        end else if (h == `BLUE_CROWN_H && v == `BLUE_CROWN_V) begin
            c.owner = game_pkg::BLUE;
            c.piece = game_pkg::CROWN;
            c.troop = game_pkg::troop_t'(`BLUE_CROWN_TROOP);
        end else if (h == v) begin
            c.piece = game_pkg::CITY;
        end else if (h + v == `MOUNTAIN_SUM) begin
            c.piece = game_pkg::MOUNTAIN;
        end else begin
            c.piece = game_pkg::TERRITORY;
        end
        return c;
    endfunction

    function automatic logic [2:0] random_code();
        int r;
        r = $urandom_range(0, 15);
        if (r < 10) return 3'(r % 4);        // directions weighted up
        if (r < 12) return 3'(game_pkg::SELECT);
        if (r < 14) return 3'(game_pkg::TOGGLE);
        return 3'(r - 8);                    // 6 or 7
    endfunction

    // one classic read with a single ack
    task automatic wb_read(game_pkg::pos_t p, output game_pkg::cell_t c);
        int t;
        t = 0;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_adr = p;
        do begin
            @(posedge clk_100M);
            #1;
            t++;
        end while (!wb_ack && t < WB_TIMEOUT);
        if (!wb_ack) report_timeout("wb_ack");
        c = game_pkg::cell_t'(wb_dat_o[$bits(game_pkg::cell_t)-1:0]);
        if (wb_dat_o[`WB_DAT_W-1:$bits(game_pkg::cell_t)] !== '0) begin
            err_proto++;
            $display("read of address %h did not zero-extend the cell data", p);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        @(posedge clk_100M);
        #1;
        if (wb_ack) begin
            err_proto++;
            $display("read of address %h got more than one ack", p);
        end
    endtask

    task automatic sweep_board(string name);
        game_pkg::cell_t c;
        for (int h = 0; h < W; h++) begin
            for (int v = 0; v < W; v++) begin
                wb_read('{h: game_pkg::coord_t'(h), v: game_pkg::coord_t'(v)}, c);
                check_cell(name, board[h][v], c);
                repeat ($urandom_range(0, 3)) begin  // random spacing
                    @(posedge clk_100M);
                    #1;
                end
            end
        end
    endtask

    task automatic send_key(logic [2:0] code);
        int t;
        @(posedge clk_100M);     // ready low for a cycle between keys
        #1;
        keyboard_data  = code;
        keyboard_ready = 1'b1;
        t = 0;
        do begin
            @(posedge clk_100M);
            #1;
            t++;
        end while (!keyboard_read_fin && t < KEY_TIMEOUT);
        if (!keyboard_read_fin) report_timeout("keyboard_read_fin");
        keyboard_ready = 1'b0;
        t = 0;
        while (status.busy && t < BUSY_TIMEOUT) begin
            @(posedge clk_100M);
            #1;
            t++;
        end
        if (status.busy) report_timeout("busy to fall");
    endtask

    task automatic play_op(logic [2:0] code);
        game_pkg::pos_t         src;
        game_pkg::pos_t         tgt;
        game_pkg::cell_t        c;
        game_pkg::troop_t       s_troop;
        game_pkg::troop_t       t_troop;
        game_pkg::game_status_t exp;
        logic                   ok;
        logic                   capture;
        logic                   blocked;
        string                  name;
        src     = m_cursor;
        tgt     = src;
        ok      = 1'b0;
        capture = 1'b0;
        blocked = 1'b0;
        name    = "ignored code";
        case (code)
            3'd0: begin
                ok    = (src.v != 0);
                tgt.v = game_pkg::coord_t'(src.v - 1);
            end
            3'd1: begin
                ok    = (src.h != 0);
                tgt.h = game_pkg::coord_t'(src.h - 1);
            end
            3'd2: begin
                ok    = (src.v < W - 1);
                tgt.v = game_pkg::coord_t'(src.v + 1);
            end
            3'd3: begin
                ok    = (src.h < W - 1);
                tgt.h = game_pkg::coord_t'(src.h + 1);
            end
            default: ;
        endcase
        if (code <= 3'd5 && m_mode == game_pkg::CHOOSE) begin
            if (code < 3'd4) begin
                name = "cursor move";
                if (ok) m_cursor = tgt;    // clamps at the edge
            end else if (code == game_pkg::SELECT) begin
                name = "select";
                if (board[src.h][src.v].owner == m_player &&
                    board[src.h][src.v].troop >= `MIN_MOVE_TROOP) m_mode = game_pkg::MOVE_TOTAL;
            end else begin
                name = "toggle";
            end
        end else if (code == game_pkg::TOGGLE) begin
            name   = "toggle";
            m_mode = (m_mode == game_pkg::MOVE_TOTAL) ? game_pkg::MOVE_HALF : game_pkg::MOVE_TOTAL;
        end else if (code == game_pkg::SELECT) begin
            name   = "select";
            m_mode = game_pkg::CHOOSE;
        end else if (code < 3'd4 && ok && board[tgt.h][tgt.v].owner == game_pkg::NPC &&
                     board[tgt.h][tgt.v].piece inside {game_pkg::TERRITORY, game_pkg::CITY}) begin
            name    = "capture";
            capture = 1'b1;
            s_troop = board[src.h][src.v].troop;
            if (m_mode == game_pkg::MOVE_TOTAL) begin
                t_troop = s_troop - 1;
                s_troop = 1;
            end else begin
                t_troop = s_troop >> 1;
                s_troop = s_troop - t_troop;
            end
            board[tgt.h][tgt.v].owner = m_player;
            board[tgt.h][tgt.v].troop = t_troop;
            board[src.h][src.v].troop = s_troop;
            m_player = (m_player == game_pkg::RED) ? game_pkg::BLUE : game_pkg::RED;
            if (m_player == game_pkg::RED) m_round++;
            if (m_player == game_pkg::RED) begin
                m_cursor = '{h: game_pkg::coord_t'(`RED_CROWN_H),
                             v: game_pkg::coord_t'(`RED_CROWN_V)};
            end else begin
                m_cursor = '{h: game_pkg::coord_t'(`BLUE_CROWN_H),
                             v: game_pkg::coord_t'(`BLUE_CROWN_V)};
            end
            m_mode = game_pkg::CHOOSE;
        end else if (code < 3'd4) begin
            name    = "blocked move";     // mountain, owned cell or edge
            blocked = 1'b1;
        end
        send_key(code);
        exp = '{cursor: m_cursor, mode: m_mode, player: m_player, round: m_round, busy: 1'b0};
        check_status(name, exp, status);
        check_pos(name, m_cursor, status.cursor);
        check_round(name, m_round, status.round);
        if (capture || blocked) begin
            wb_read(src, c);
            check_cell({name, " source"}, board[src.h][src.v], c);
            if (ok) begin
                wb_read(tgt, c);
                check_cell({name, " target"}, board[tgt.h][tgt.v], c);
            end
        end
    endtask

    initial begin
        game_pkg::cell_t        c;
        game_pkg::game_status_t exp;
        clk_100M       = 1'b0;
        reset          = 1'b1;
        keyboard_ready = 1'b0;
        keyboard_data  = '0;
        wb_cyc         = 1'b0;
        wb_stb         = 1'b0;
        wb_adr         = '0;
        err_value      = 0;
        err_proto      = 0;
        void'($urandom(32'h74692890));
        for (int h = 0; h < W; h++) begin
            for (int v = 0; v < W; v++) begin
                board[h][v] = layout_cell(h, v);
            end
        end
        m_cursor = '0;
        m_mode   = game_pkg::CHOOSE;
        m_player = game_pkg::RED;
        m_round  = 1;
        repeat (10) @(posedge clk_100M);
        #1;
        reset = 1'b0;
        @(posedge clk_100M);
        #1;
        exp = '{cursor: m_cursor, mode: m_mode, player: m_player, round: m_round, busy: 1'b0};
        check_status("after reset", exp, status);
        check_pos("after reset", m_cursor, status.cursor);
        check_round("after reset", m_round, status.round);
        sweep_board("layout sweep");
        wb_read(game_pkg::pos_t'(8'hA5), c);   // h = 10 is off the board
        check_cell("off-board read", '0, c);
        foreach (opening[i]) play_op(opening[i]);
        for (int i = 0; i < NUM_OPS; i++) begin
            play_op(random_code());
        end
        sweep_board("final sweep");
        end_run();
    end

endmodule

// File: project.f
+incdir+.
game_pkg.sv
key_intake.sv
cursor_unit.sv
round_counter.sv
board_store.sv
game_fsm.sv
game_player.sv
game_player_chk.sv
tb_game_player.sv

// File: Bender.yml
package:
  name: game_player

sources:
  - include_dirs:
      - .
    files:
      - game_pkg.sv
      - key_intake.sv
      - cursor_unit.sv
      - round_counter.sv
      - board_store.sv
      - game_fsm.sv
      - game_player.sv
  - target: test
    include_dirs:
      - .
    files:
      - game_player_chk.sv
      - tb_game_player.sv
